//--- verilog/gat_defs.svh
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// Data widths
`define GAT_DATA_W          8
`define GAT_COL_W           3
`define GAT_WH_W            20
`define GAT_COEF_W          32

// Matrix shapes
`define GAT_F_IN            8
`define GAT_F_OUT           4
`define GAT_W_NUM           (`GAT_F_IN * `GAT_F_OUT)
`define GAT_A_NUM           (2 * `GAT_F_OUT)

// Negative slope of the LeakyReLU is 2^-3
`define GAT_LEAKY_SHIFT     3

// Coefficient FIFO
`define GAT_COEF_FF_DEPTH   16
`define GAT_COEF_FF_MARGIN  4

`endif

//--- verilog/gat_pkg.sv
`default_nettype none

`include "gat_defs.svh"

package gat_pkg;

  // H values, weights and a values
  typedef logic signed [`GAT_DATA_W-1:0] data_t;

  // Column of an H entry, selects one row of W
  typedef logic [`GAT_COL_W-1:0] col_idx_t;

  // One element of a projected feature row
  typedef logic signed [`GAT_WH_W-1:0] wh_t;

  // Attention coefficient
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  typedef enum logic [1:0] {
    LOAD_W,
    LOAD_A,
    LOADED
  } load_state_e;

endpackage

`default_nettype wire

//--- verilog/gat_param_loader.sv
`default_nettype none

`include "gat_defs.svh"

module gat_param_loader import gat_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       wgt_vld_i,
  input  wire data_t                wgt_i,
  input  wire                       a_vld_i,
  input  wire data_t                a_i,
  output data_t [`GAT_W_NUM-1:0]    w_flat_o,
  output data_t [`GAT_A_NUM-1:0]    a_flat_o,
  output logic                      params_ready_o
);

  localparam int IDX_W = $clog2(`GAT_W_NUM);

  load_state_e            state;
  logic [IDX_W-1:0]       idx;
  data_t [`GAT_W_NUM-1:0] w_q;
  data_t [`GAT_A_NUM-1:0] a_q;

  // Shared index walks W first, then a
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= LOAD_W;
      idx   <= '0;
    end else begin
      case (state)
        LOAD_W: begin
          if (wgt_vld_i) begin
            if (idx == IDX_W'(`GAT_W_NUM - 1)) begin
              state <= LOAD_A;
              idx   <= '0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        LOAD_A: begin
          if (a_vld_i) begin
            if (idx == IDX_W'(`GAT_A_NUM - 1)) begin
              state <= LOADED;
              idx   <= '0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: begin
          state <= LOADED;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOAD_W && wgt_vld_i) begin
      w_q[idx] <= wgt_i;
    end
    if (state == LOAD_A && a_vld_i) begin
      a_q[idx] <= a_i;
    end
  end

  assign w_flat_o       = w_q;
  assign a_flat_o       = a_q;
  assign params_ready_o = (state == LOADED);

  // Weights only while W is loading, a values only while a is loading
  a_wgt_in_state: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_vld_i |-> state == LOAD_W)
    else $error("weight strobe outside LOAD_W");

  a_a_in_state: assert property (@(posedge clk) disable iff (!rst_n)
    a_vld_i |-> state == LOAD_A)
    else $error("a strobe outside LOAD_A");

endmodule

`default_nettype wire

//--- verilog/gat_spmm.sv
`default_nettype none

`include "gat_defs.svh"

module gat_spmm import gat_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       h_vld_i,
  input  wire data_t                h_val_i,
  input  wire col_idx_t             h_col_i,
  input  wire                       h_first_i,
  input  wire                       h_last_i,
  input  wire data_t [`GAT_W_NUM-1:0] w_flat_i,
  output logic                      wh_vld_o,
  output wh_t [`GAT_F_OUT-1:0]      wh_row_o,
  output logic                      wh_first_o
);

  logic signed [2*`GAT_DATA_W-1:0] prod    [`GAT_F_OUT];
  wh_t                             sum_nxt [`GAT_F_OUT];
  wh_t                             acc     [`GAT_F_OUT];
  logic                            row_open;
  logic                            row_first_q;

  // Row h_col_i of W times the entry value, added to the running sums
  always_comb begin
    for (int j = 0; j < `GAT_F_OUT; j++) begin
      prod[j]    = h_val_i * w_flat_i[int'(h_col_i) * `GAT_F_OUT + j];
      sum_nxt[j] = acc[j] + wh_t'(prod[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
      row_open <= 1'b0;
      for (int j = 0; j < `GAT_F_OUT; j++) begin
        acc[j] <= '0;
      end
    end else begin
      wh_vld_o <= h_vld_i && h_last_i;
      if (h_vld_i) begin
        row_open <= !h_last_i;
        for (int j = 0; j < `GAT_F_OUT; j++) begin
          acc[j] <= h_last_i ? '0 : sum_nxt[j];
        end
      end
    end
  end

  // Finished row includes the closing entry
  always_ff @(posedge clk) begin
    if (h_vld_i && h_last_i) begin
      for (int j = 0; j < `GAT_F_OUT; j++) begin
        wh_row_o[j] <= sum_nxt[j];
      end
      wh_first_o <= h_first_i;
    end
    if (h_vld_i) begin
      row_first_q <= h_first_i;
    end
  end

  a_first_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (h_vld_i && row_open) |-> h_first_i == row_first_q)
    else $error("h_first_i changed inside a row");

endmodule

`default_nettype wire

//--- verilog/gat_dmvm.sv
`default_nettype none

`include "gat_defs.svh"

module gat_dmvm import gat_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       wh_vld_i,
  input  wire wh_t [`GAT_F_OUT-1:0] wh_row_i,
  input  wire                       wh_first_i,
  input  wire data_t [`GAT_A_NUM-1:0] a_flat_i,
  output logic                      coef_wr_o,
  output logic [`GAT_COEF_W:0]      coef_din_o
);

  coef_t dot_l;
  coef_t dot_r;
  coef_t self_left_q;
  logic  s1_vld;
  logic  s1_first;
  coef_t s1_left;
  coef_t s1_right;
  coef_t s2_sum;
  coef_t s2_leaky;

  // Left half of a pairs with the self node, right half with this node
  always_comb begin
    dot_l = '0;
    dot_r = '0;
    for (int j = 0; j < `GAT_F_OUT; j++) begin
      dot_l = dot_l + coef_t'(a_flat_i[j]) * coef_t'(wh_row_i[j]);
      dot_r = dot_r + coef_t'(a_flat_i[`GAT_F_OUT + j]) * coef_t'(wh_row_i[j]);
    end
  end

  // Stage 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      // Self row uses its own left product and becomes the new reference
      s1_left  <= wh_first_i ? dot_l : self_left_q;
      s1_right <= dot_r;
      s1_first <= wh_first_i;
      if (wh_first_i) begin
        self_left_q <= dot_l;
      end
    end
  end

  // Stage 2, LeakyReLU by arithmetic shift rounds toward minus infinity
  always_comb begin
    s2_sum   = s1_left + s1_right;
    s2_leaky = s2_sum[`GAT_COEF_W-1] ? (s2_sum >>> `GAT_LEAKY_SHIFT) : s2_sum;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o <= 1'b0;
    end else begin
      coef_wr_o <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      coef_din_o <= {s1_first, s2_leaky};
    end
  end

endmodule

`default_nettype wire

//--- verilog/gat_coef_fifo.sv
`default_nettype none

module gat_coef_fifo #(
  parameter int WIDTH = 33,
  parameter int DEPTH = 16
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         wr_i,
  input  wire [WIDTH-1:0]             din_i,
  input  wire                         rd_i,
  output logic [WIDTH-1:0]            dout_o,
  output logic                        empty_o,
  output logic [$clog2(DEPTH+1)-1:0]  free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count == CNT_W'(DEPTH));
  assign wr_en = wr_i && !full;
  assign rd_en = rd_i && !empty_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Head shown ahead of the read
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign free_o  = CNT_W'(DEPTH) - count;

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_i |-> !full)
    else $error("write to full FIFO");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd_i |-> !empty_o)
    else $error("read from empty FIFO");

endmodule

`default_nettype wire

//--- verilog/gat_top.sv
`default_nettype none

`include "gat_defs.svh"

module gat_top import gat_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         wgt_vld_i,
  input  wire data_t  wgt_i,
  input  wire         a_vld_i,
  input  wire data_t  a_i,
  input  wire         h_vld_i,
  input  wire data_t  h_val_i,
  input  wire col_idx_t h_col_i,
  input  wire         h_first_i,
  input  wire         h_last_i,
  output logic        h_rdy_o,
  input  wire         coef_rd_i,
  output logic        coef_empty_o,
  output coef_t       coef_o,
  output logic        coef_first_o
);

  localparam int FREE_W = $clog2(`GAT_COEF_FF_DEPTH + 1);

  data_t [`GAT_W_NUM-1:0] w_flat;
  data_t [`GAT_A_NUM-1:0] a_flat;
  logic                   params_ready;
  logic                   wh_vld;
  wh_t [`GAT_F_OUT-1:0]   wh_row;
  logic                   wh_first;
  logic                   coef_wr;
  logic [`GAT_COEF_W:0]   coef_din;
  logic [`GAT_COEF_W:0]   coef_head;
  logic [FREE_W-1:0]      coef_free;

  gat_param_loader u_loader (
    .clk            (clk),
    .rst_n          (rst_n),
    .wgt_vld_i      (wgt_vld_i),
    .wgt_i          (wgt_i),
    .a_vld_i        (a_vld_i),
    .a_i            (a_i),
    .w_flat_o       (w_flat),
    .a_flat_o       (a_flat),
    .params_ready_o (params_ready)
  );

  gat_spmm u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .h_vld_i    (h_vld_i),
    .h_val_i    (h_val_i),
    .h_col_i    (h_col_i),
    .h_first_i  (h_first_i),
    .h_last_i   (h_last_i),
    .w_flat_i   (w_flat),
    .wh_vld_o   (wh_vld),
    .wh_row_o   (wh_row),
    .wh_first_o (wh_first)
  );

  gat_dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_vld_i   (wh_vld),
    .wh_row_i   (wh_row),
    .wh_first_i (wh_first),
    .a_flat_i   (a_flat),
    .coef_wr_o  (coef_wr),
    .coef_din_o (coef_din)
  );

  gat_coef_fifo #(
    .WIDTH (`GAT_COEF_W + 1),
    .DEPTH (`GAT_COEF_FF_DEPTH)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef_din),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_head),
    .empty_o (coef_empty_o),
    .free_o  (coef_free)
  );

  // Margin slots absorb rows still in the pipeline
  assign h_rdy_o = params_ready && (coef_free > FREE_W'(`GAT_COEF_FF_MARGIN));

  assign coef_first_o = coef_head[`GAT_COEF_W];
  assign coef_o       = coef_head[`GAT_COEF_W-1:0];

endmodule

`default_nettype wire

//--- tests/tb_gat_top.sv
`default_nettype none

`include "gat_defs.svh"

module tb_gat_top import gat_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RANDOM = 40;
  localparam int BP_GRAPHS  = 8;
  localparam int BP_ROWS    = 4;
  localparam int MAX_ROWS   = NUM_RANDOM * 5 + 5 + BP_GRAPHS * BP_ROWS;
  // Allows 4 entries per row at one pop every other cycle plus stall and drain time
  localparam int STIM_CYCLES = 10 + `GAT_W_NUM + `GAT_A_NUM + MAX_ROWS * 4 * 2 + 800;

  logic     clk       = 1'b0;
  logic     rst_n     = 1'b0;
  logic     coef_rd_i = 1'b0;
  logic     wgt_vld_i;
  data_t    wgt_i;
  logic     a_vld_i;
  data_t    a_i;
  logic     h_vld_i;
  data_t    h_val_i;
  col_idx_t h_col_i;
  logic     h_first_i;
  logic     h_last_i;
  logic     h_rdy_o;
  logic     coef_empty_o;
  coef_t    coef_o;
  logic     coef_first_o;

  logic [31:0]          rng_state   = 32'd60741;
  logic                 read_en     = 1'b0;
  logic                 params_done = 1'b0;
  int                   w_m [`GAT_F_IN][`GAT_F_OUT];
  int                   a_m [`GAT_A_NUM];
  int                   self_wh [`GAT_F_OUT];
  logic [`GAT_COEF_W:0] exp_q [$];
  logic [`GAT_COEF_W:0] head_exp;
  int errors       = 0;
  int flag_errs    = 0;
  int firsts_seen  = 0;
  int neg_seen     = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  gat_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_vld_i    (wgt_vld_i),
    .wgt_i        (wgt_i),
    .a_vld_i      (a_vld_i),
    .a_i          (a_i),
    .h_vld_i      (h_vld_i),
    .h_val_i      (h_val_i),
    .h_col_i      (h_col_i),
    .h_first_i    (h_first_i),
    .h_last_i     (h_last_i),
    .h_rdy_o      (h_rdy_o),
    .coef_rd_i    (coef_rd_i),
    .coef_empty_o (coef_empty_o),
    .coef_o       (coef_o),
    .coef_first_o (coef_first_o)
  );

  always #4 clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return lo + int'((rng_state >> 8) % 32'(hi - lo + 1));
  endfunction

  // Floor of s / 2^shift for negative sums
  function automatic int leaky_relu(input int s);
    int div;
    div = 1 << `GAT_LEAKY_SHIFT;
    if (s >= 0) begin
      return s;
    end
    return -((-s + div - 1) / div);
  endfunction

  function automatic void push_expected(input int wh [`GAT_F_OUT], input bit first);
    int sum;
    sum = 0;
    for (int j = 0; j < `GAT_F_OUT; j++) begin
      if (first) begin
        // Self row pairs both halves of a with its own Wh
        self_wh[j] = wh[j];
        sum += (a_m[j] + a_m[`GAT_F_OUT + j]) * wh[j];
      end else begin
        sum += a_m[j] * self_wh[j] + a_m[`GAT_F_OUT + j] * wh[j];
      end
    end
    if (sum < 0) begin
      neg_seen++;
    end
    exp_q.push_back({first, coef_t'(leaky_relu(sum))});
  endfunction

  task automatic load_params();
    int v;
    for (int k = 0; k < `GAT_W_NUM + `GAT_A_NUM; k++) begin
      v = rand_range(-128, 127);
      @(posedge clk);
      if (k < `GAT_W_NUM) begin
        w_m[k / `GAT_F_OUT][k % `GAT_F_OUT] = v;
        wgt_vld_i <= 1'b1;
        wgt_i     <= data_t'(v);
      end else begin
        a_m[k - `GAT_W_NUM] = v;
        wgt_vld_i <= 1'b0;
        a_vld_i   <= 1'b1;
        a_i       <= data_t'(v);
      end
    end
    @(posedge clk);
    a_vld_i     <= 1'b0;
    params_done <= 1'b1;
  endtask

  task automatic send_entry(input int val, input int col, input bit first, input bit last);
    @(posedge clk);
    while (!h_rdy_o) begin
      h_vld_i <= 1'b0;
      @(posedge clk);
    end
    h_vld_i   <= 1'b1;
    h_val_i   <= data_t'(val);
    h_col_i   <= col_idx_t'(col);
    h_first_i <= first;
    h_last_i  <= last;
  endtask

  task automatic send_subgraph(input int n_rows, input bit same_col);
    int wh [`GAT_F_OUT];
    int len;
    int col;
    int val;
    int fixed_col;
    for (int r = 0; r < n_rows; r++) begin
      len       = same_col ? rand_range(2, 4) : rand_range(1, 4);
      fixed_col = rand_range(0, `GAT_F_IN - 1);
      for (int j = 0; j < `GAT_F_OUT; j++) begin
        wh[j] = 0;
      end
      for (int e = 0; e < len; e++) begin
        col = same_col ? fixed_col : rand_range(0, `GAT_F_IN - 1);
        val = rand_range(-128, 127);
        for (int j = 0; j < `GAT_F_OUT; j++) begin
          wh[j] += val * w_m[col][j];
        end
        send_entry(val, col, r == 0, e == len - 1);
      end
      push_expected(wh, r == 0);
    end
    @(posedge clk);
    h_vld_i <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d coefficients never arrived", exp_q.size());
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, errs);
    end
  endtask

  // Pops every other cycle and never on an empty FIFO
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_rd_i <= 1'b0;
    end else begin
      coef_rd_i <= read_en && !coef_empty_o && !coef_rd_i;
    end
  end

  always @(posedge clk) begin
    if (rst_n && coef_rd_i && !coef_empty_o) begin
      if (exp_q.size() == 0) begin
        $display("A coefficient was popped with no row outstanding");
        errors++;
      end else begin
        head_exp = exp_q.pop_front();
        if (coef_first_o) begin
          firsts_seen++;
        end
        assert (coef_o == coef_t'(head_exp[`GAT_COEF_W-1:0])) else begin
          $display("Error: coef_o is 0x%h, expected 0x%h", coef_o,
                   head_exp[`GAT_COEF_W-1:0]);
          errors++;
        end
        assert (coef_first_o == head_exp[`GAT_COEF_W]) else begin
          $display("Error: coef_first_o is 0x%h, expected 0x%h", coef_first_o,
                   head_exp[`GAT_COEF_W]);
          errors++;
          flag_errs++;
        end
      end
    end
  end

  a_locked: assert property (@(posedge clk) disable iff (!rst_n)
    !params_done |-> !h_rdy_o && coef_empty_o)
    else begin
      $display("h_rdy_o or coef_empty_o active before the parameters were loaded");
      errors++;
    end

  a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
    coef_rd_i |-> !coef_empty_o)
    else begin
      $display("The FIFO was read while empty");
      errors++;
    end

  initial begin
    #(STIM_CYCLES * 8 * 4);
    $display("Timeout after %0d cycles, the FIFO never drained", STIM_CYCLES * 4);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int e0;
    int f0;
    int n;
    wgt_vld_i = 1'b0;
    wgt_i     = '0;
    a_vld_i   = 1'b0;
    a_i       = '0;
    h_vld_i   = 1'b0;
    h_val_i   = '0;
    h_col_i   = '0;
    h_first_i = 1'b0;
    h_last_i  = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    e0 = errors;
    repeat (5) @(posedge clk);
    load_params();
    @(posedge clk);
    assert (h_rdy_o) else begin
      $display("h_rdy_o stayed low after the parameters were loaded");
      errors++;
    end
    report_test("parameter load", errors - e0);

    e0 = errors;
    f0 = flag_errs;
    read_en <= 1'b1;
    for (int g = 0; g < NUM_RANDOM; g++) begin
      send_subgraph(rand_range(1, 5), 1'b0);
    end
    wait_drain(400);
    if (neg_seen == 0) begin
      $display("No negative sum reached the LeakyReLU");
      errors++;
    end
    report_test("random subgraphs", (errors - e0) - (flag_errs - f0));
    if (firsts_seen != NUM_RANDOM) begin
      $display("Saw %0d self-node flags for %0d subgraphs", firsts_seen, NUM_RANDOM);
      errors++;
      flag_errs++;
    end
    report_test("self-node flag", flag_errs - f0);

    e0 = errors;
    send_subgraph(5, 1'b1);
    wait_drain(200);
    report_test("repeated columns", errors - e0);

    e0 = errors;
    @(posedge clk);
    read_en <= 1'b0;
    fork
      begin
        for (int g = 0; g < BP_GRAPHS; g++) begin
          send_subgraph(BP_ROWS, 1'b0);
        end
      end
      begin
        n = 0;
        @(posedge clk);
        while (h_rdy_o && n < 400) begin
          @(posedge clk);
          n++;
        end
        if (h_rdy_o) begin
          $display("h_rdy_o never dropped with reads stopped");
          errors++;
        end
        // Rows in flight settle into the margin slots
        repeat (8) @(posedge clk);
        if (exp_q.size() > `GAT_COEF_FF_DEPTH || coef_empty_o || h_rdy_o) begin
          $display("Stall left %0d rows for a %0d-entry FIFO", exp_q.size(),
                   `GAT_COEF_FF_DEPTH);
          errors++;
        end
        read_en <= 1'b1;
      end
    join
    wait_drain(400);
    report_test("back-pressure", errors - e0);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gat.f
+incdir+verilog
verilog/gat_pkg.sv
verilog/gat_param_loader.sv
verilog/gat_spmm.sv
verilog/gat_dmvm.sv
verilog/gat_coef_fifo.sv
verilog/gat_top.sv
tests/tb_gat_top.sv

//--- Makefile
BIN := obj_dir/Vtb_gat_top

$(BIN): gat.f verilog/gat_defs.svh $(filter-out +%,$(shell cat gat.f))
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_gat_top -f gat.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: run clean
